//--- sim.f
+incdir+hw
hw/nw_pkt_pkg.sv
hw/nw_route_pkg.sv
hw/route_decoder.sv
hw/t_arbiter.sv
hw/t_switch.sv
hw/root_switch.sv
hw/leaf_port.sv
hw/fat_tree_nw4.sv
tb/nw_checker.sv
tb/tb_top.sv

//--- run.sh
#!/bin/sh
# build the fat tree testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timescale 1ns/1ps --top-module tb_top -f sim.f -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/tb_top_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All tests passed" "$log"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1

//--- tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "nw_defines.svh"

module tb_top;

	localparam int num_rows = 12;
	localparam int idle_cycles = 20;
	localparam int inject_timeout = 100;
	localparam int deliver_timeout = 200;
	localparam int report_timeout = 8;
	localparam logic [31:0] lfsr_seed = 32'h18ad;
	// right shift galois taps, maximal length
	localparam logic [31:0] lfsr_taps = 32'ha300_0000;

	// per source fields run from source 3 down to source 0
	typedef struct packed {
		logic burst;
		logic [`NW_NUM_LEAVES-1:0] src_mask;
		nw_pkt_pkg::leaf_addr_t [`NW_NUM_LEAVES-1:0] dest;
		nw_pkt_pkg::payload_t [`NW_NUM_LEAVES-1:0] payload;
	} stim_row_t;

	logic clk;
	logic reset;
	nw_pkt_pkg::packet_t pe_in [`NW_NUM_LEAVES];
	nw_pkt_pkg::packet_t pe_out [`NW_NUM_LEAVES];
	logic [`NW_NUM_LEAVES-1:0] resend;
	logic lone;
	logic test_end;
	int test_id;
	logic report;
	int chk_errors;
	logic chk_reported;

	stim_row_t stim_table [num_rows];
	logic [31:0] lfsr_state;
	// packets of the current row and how far they got
	nw_pkt_pkg::packet_t row_pkt [`NW_NUM_LEAVES];
	logic [`NW_NUM_LEAVES-1:0] taken;
	logic [`NW_NUM_LEAVES-1:0] arrived;
	logic aborted;

	fat_tree_nw4 dut_i (
		.clk(clk),
		.reset(reset),
		.pe_pkt_i(pe_in),
		.pe_pkt_o(pe_out),
		.resend_o(resend)
	);

	nw_checker chk_i (
		.clk(clk),
		.reset(reset),
		.pe_in_i(pe_in),
		.pe_out_i(pe_out),
		.resend_i(resend),
		.lone_i(lone),
		.test_end_i(test_end),
		.test_id_i(test_id),
		.report_i(report),
		.errors_o(chk_errors),
		.reported_o(chk_reported)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] galois_step(input logic [31:0] s);
		if (s[0])
			galois_step = (s >> 1) ^ lfsr_taps;
		else
			galois_step = s >> 1;
	endfunction

	task automatic draw_payload(output nw_pkt_pkg::payload_t p);
		p = '0;
		for (int b = 0; b < `NW_PAYLOAD_W; b++) begin
			p = {p[`NW_PAYLOAD_W-2:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
	endtask

	// burst, source mask, dest, payload; burst rows draw their payloads
	task automatic load_table();
		stim_table[0] = {1'b0, 4'b0000, 8'b00_00_00_00, 24'h0};
		stim_table[1] = {1'b0, 4'b0001, 8'b00_00_00_01, {18'h0, 6'h15}};
		stim_table[2] = {1'b0, 4'b0100, 8'b00_10_00_00, {6'h00, 6'h2a, 12'h0}};
		stim_table[3] = {1'b0, 4'b0001, 8'b00_00_00_11, {18'h0, 6'h0f}};
		stim_table[4] = {1'b0, 4'b1000, 8'b01_00_00_00, {6'h33, 18'h0}};
		// everyone to one leaf forces deflection and resend
		stim_table[5] = {1'b1, 4'b1111, 8'b01_01_01_01, 24'h0};
		stim_table[6] = {1'b1, 4'b1111, 8'b10_10_10_10, 24'h0};
		stim_table[7] = {1'b1, 4'b1111, 8'b00_01_10_11, 24'h0};
		stim_table[8] = {1'b1, 4'b1111, 8'b11_00_10_10, 24'h0};
		stim_table[9] = {1'b1, 4'b1111, 8'b10_11_00_01, 24'h0};
		stim_table[10] = {1'b1, 4'b1111, 8'b11_11_11_00, 24'h0};
		stim_table[11] = {1'b1, 4'b0110, 8'b00_01_00_00, 24'h0};
	endtask

	task automatic note_arrivals();
		logic found;
		for (int j = 0; j < `NW_NUM_LEAVES; j++) begin
			found = 1'b0;
			for (int i = 0; i < `NW_NUM_LEAVES; i++) begin
				if (pe_out[j].valid && !found && !arrived[i]
						&& row_pkt[i].dest == nw_pkt_pkg::leaf_addr_t'(j)
						&& row_pkt[i].payload == pe_out[j].payload) begin
					arrived[i] = 1'b1;
					found = 1'b1;
				end
			end
		end
	endtask

	task automatic run_row(input int r);
		stim_row_t row;
		nw_pkt_pkg::payload_t pl;
		int cnt;
		row = stim_table[r];
		for (int i = 0; i < `NW_NUM_LEAVES; i++) begin
			row_pkt[i] = '0;
			if (row.src_mask[i]) begin
				if (row.burst)
					draw_payload(pl);
				else
					pl = row.payload[i];
				row_pkt[i].valid = 1'b1;
				row_pkt[i].dest = row.dest[i];
				row_pkt[i].payload = pl;
			end
		end
		taken = ~row.src_mask;
		arrived = ~row.src_mask;
		@(posedge clk);
		lone <= ~row.burst;
		test_id <= r;
		for (int i = 0; i < `NW_NUM_LEAVES; i++)
			pe_in[i] <= row_pkt[i];
		// hold each packet until an edge without resend takes it
		cnt = 0;
		while (taken != '1 && cnt < inject_timeout) begin
			@(posedge clk);
			cnt++;
			note_arrivals();
			for (int i = 0; i < `NW_NUM_LEAVES; i++) begin
				if (!taken[i] && !resend[i]) begin
					taken[i] = 1'b1;
					pe_in[i] <= '0;
				end
			end
		end
		cnt = 0;
		while (taken == '1 && arrived != '1 && cnt < deliver_timeout) begin
			@(posedge clk);
			cnt++;
			note_arrivals();
		end
		for (int i = 0; i < `NW_NUM_LEAVES; i++) begin
			if (!taken[i])
				$display("Timeout: leaf %0d could not inject its packet for leaf %0d, payload 0x%02h",
					i, row_pkt[i].dest, row_pkt[i].payload);
			else if (!arrived[i])
				$display("Timeout: leaf %0d never received the packet from leaf %0d, payload 0x%02h",
					row_pkt[i].dest, i, row_pkt[i].payload);
		end
		if (taken != '1 || arrived != '1) begin
			aborted = 1'b1;
		end else begin
			// idle row leaves the network quiet for the checker to watch
			if (row.src_mask == '0)
				repeat (idle_cycles) @(posedge clk);
			test_end <= 1'b1;
			@(posedge clk);
			test_end <= 1'b0;
		end
	endtask

	initial begin
		int cnt;
		reset <= 1'b1;
		for (int i = 0; i < `NW_NUM_LEAVES; i++)
			pe_in[i] <= '0;
		lone <= 1'b1;
		test_end <= 1'b0;
		test_id <= 0;
		report <= 1'b0;
		aborted = 1'b0;
		lfsr_state = lfsr_seed;
		load_table();
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		for (int r = 0; r < num_rows && !aborted; r++)
			run_row(r);
		// quiet tail so a late duplicate still reaches the checker
		repeat (idle_cycles) @(posedge clk);
		report <= 1'b1;
		cnt = 0;
		while (!chk_reported && cnt < report_timeout) begin
			@(posedge clk);
			cnt++;
		end
		if (!chk_reported)
			$display("Timeout: the checker never reported its counts");
		if (aborted || !chk_reported || chk_errors != 0)
			$display("Some tests failed");
		else
			$display("All tests passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/nw_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "nw_defines.svh"

module nw_checker (
	input wire clk,
	input wire reset,
	input wire nw_pkt_pkg::packet_t pe_in_i [`NW_NUM_LEAVES],
	input wire nw_pkt_pkg::packet_t pe_out_i [`NW_NUM_LEAVES],
	input wire [`NW_NUM_LEAVES-1:0] resend_i,
	input wire lone_i,
	input wire test_end_i,
	input wire [31:0] test_id_i,
	input wire report_i,
	output int errors_o,
	output logic reported_o
);

	typedef struct packed {
		int cycle;
		nw_pkt_pkg::leaf_addr_t src;
		nw_pkt_pkg::packet_t pkt;
	} inflight_t;

	// injections taken by the network and not yet delivered
	inflight_t inflight [$];
	int cycle;
	int errors;
	int test_errors;
	int test_delivered;
	int test_injected;
	logic [`NW_NUM_LEAVES-1:0] test_dests;
	logic test_resend;
	int tests_run;
	int tests_failed;
	int injected;
	int delivered;

	task automatic count_error();
		errors++;
		test_errors++;
	endtask

	task automatic record_injection(input int leaf);
		inflight_t entry;
		entry.cycle = cycle;
		entry.src = nw_pkt_pkg::leaf_addr_t'(leaf);
		entry.pkt = pe_in_i[leaf];
		inflight.push_back(entry);
		test_dests[entry.pkt.dest] = 1'b1;
		test_injected++;
		injected++;
	endtask

	task automatic check_delivery(input int leaf);
		nw_pkt_pkg::packet_t pkt;
		int hit;
		int latency;
		pkt = pe_out_i[leaf];
		hit = -1;
		for (int k = 0; k < inflight.size(); k++) begin
			if (hit < 0 && inflight[k].pkt == pkt)
				hit = k;
		end
		if (pkt.dest != nw_pkt_pkg::leaf_addr_t'(leaf)) begin
			$display("Mismatch at time %0t: leaf %0d received a packet for leaf %0d",
				$time, leaf, pkt.dest);
			count_error();
		end
		if (hit < 0) begin
			$display("Mismatch at time %0t: leaf %0d got payload 0x%02h matching no injection",
				$time, leaf, pkt.payload);
			count_error();
		end else begin
			// siblings share the high address bit and meet at level 1
			latency = (inflight[hit].src[`NW_ADDR_W-1] == pkt.dest[`NW_ADDR_W-1]) ? 3 : 5;
			if (lone_i && cycle - inflight[hit].cycle != latency) begin
				$display("Mismatch at time %0t: leaf %0d to leaf %0d took %0d cycles, expected %0d",
					$time, inflight[hit].src, pkt.dest, cycle - inflight[hit].cycle, latency);
				count_error();
			end
			inflight.delete(hit);
			delivered++;
			test_delivered++;
		end
	endtask

	task automatic close_test();
		if (inflight.size() != 0) begin
			$display("test %0d ended with %0d packet(s) never delivered", test_id_i,
				inflight.size());
			count_error();
			inflight.delete();
		end
		// four packets for one leaf cannot all pass without a bounce
		if (test_injected == `NW_NUM_LEAVES && $countones(test_dests) == 1
				&& !test_resend) begin
			$display("test %0d sent every packet to one leaf and resend_o never rose",
				test_id_i);
			count_error();
		end
		tests_run++;
		if (test_errors == 0) begin
			$display("test %0d (%s): ok, %0d delivered", test_id_i, lone_i ? "lone" : "burst",
				test_delivered);
		end else begin
			tests_failed++;
			$display("test %0d (%s): failed with %0d error(s)", test_id_i,
				lone_i ? "lone" : "burst", test_errors);
		end
		test_errors = 0;
		test_delivered = 0;
		test_injected = 0;
		test_dests = '0;
		test_resend = 1'b0;
	endtask

	always @(posedge clk) begin
		if (reset) begin
			inflight.delete();
			cycle = 0;
			errors = 0;
			test_errors = 0;
			test_delivered = 0;
			test_injected = 0;
			test_dests = '0;
			test_resend = 1'b0;
			tests_run = 0;
			tests_failed = 0;
			injected = 0;
			delivered = 0;
			errors_o <= 0;
			reported_o <= 1'b0;
		end else begin
			cycle++;
			for (int j = 0; j < `NW_NUM_LEAVES; j++) begin
				if (pe_out_i[j].valid)
					check_delivery(j);
			end
			// a bounce needs a packet in flight, and a lone packet never meets one
			if (resend_i != '0 && (lone_i || inflight.size() == 0)) begin
				$display("Mismatch at time %0t: resend_o is 0x%h with no contending packet",
					$time, resend_i);
				count_error();
			end
			if (resend_i != '0)
				test_resend = 1'b1;
			for (int i = 0; i < `NW_NUM_LEAVES; i++) begin
				if (pe_in_i[i].valid && !resend_i[i])
					record_injection(i);
			end
			if (test_end_i)
				close_test();
			if (report_i && !reported_o) begin
				$display("tests run %0d, failed %0d, injected %0d, delivered %0d, errors %0d",
					tests_run, tests_failed, injected, delivered, errors);
				errors_o <= errors;
				reported_o <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/fat_tree_nw4.sv
`timescale 1ns/1ps
`default_nettype none

`include "nw_defines.svh"

module fat_tree_nw4 (
	input wire clk,
	input wire reset,
	input wire nw_pkt_pkg::packet_t pe_pkt_i [`NW_NUM_LEAVES],
	output nw_pkt_pkg::packet_t pe_pkt_o [`NW_NUM_LEAVES],
	output logic [`NW_NUM_LEAVES-1:0] resend_o
);

	localparam int num_l1 = `NW_NUM_LEAVES / 2;

	// leaf to level 1 and back
	nw_pkt_pkg::packet_t leaf_up [`NW_NUM_LEAVES];
	nw_pkt_pkg::packet_t leaf_down [`NW_NUM_LEAVES];
	// level 1 to root and back
	nw_pkt_pkg::packet_t l1_up [num_l1];
	nw_pkt_pkg::packet_t l1_down [num_l1];

	for (genvar i = 0; i < `NW_NUM_LEAVES; i++) begin : g_leaf
		leaf_port #(
			.leaf_addr(nw_pkt_pkg::leaf_addr_t'(i))
		) leaf_i (
			.clk(clk),
			.reset(reset),
			.net_pkt_i(leaf_down[i]),
			.pe_pkt_i(pe_pkt_i[i]),
			.net_pkt_o(leaf_up[i]),
			.pe_pkt_o(pe_pkt_o[i]),
			.resend_o(resend_o[i])
		);
	end

	// even leaf on the left child port, odd leaf on the right
	for (genvar s = 0; s < num_l1; s++) begin : g_l1
		t_switch #(
			.node_bit(1'(s))
		) sw_i (
			.clk(clk),
			.reset(reset),
			.l_pkt_i(leaf_up[2*s]),
			.r_pkt_i(leaf_up[2*s+1]),
			.u_pkt_i(l1_down[s]),
			.l_pkt_o(leaf_down[2*s]),
			.r_pkt_o(leaf_down[2*s+1]),
			.u_pkt_o(l1_up[s])
		);
	end

	root_switch root_i (
		.clk(clk),
		.reset(reset),
		.l_pkt_i(l1_up[0]),
		.r_pkt_i(l1_up[1]),
		.l_pkt_o(l1_down[0]),
		.r_pkt_o(l1_down[1])
	);

endmodule

`default_nettype wire

//--- hw/leaf_port.sv
`timescale 1ns/1ps
`default_nettype none

module leaf_port #(
	parameter nw_pkt_pkg::leaf_addr_t leaf_addr = '0
) (
	input wire clk,
	input wire reset,
	input wire nw_pkt_pkg::packet_t net_pkt_i,
	input wire nw_pkt_pkg::packet_t pe_pkt_i,
	output nw_pkt_pkg::packet_t net_pkt_o,
	output nw_pkt_pkg::packet_t pe_pkt_o,
	output logic resend_o
);

	logic accept;
	logic bounce;

	assign accept = net_pkt_i.valid && (net_pkt_i.dest == leaf_addr);
	// a deflected packet for another leaf takes the uplink slot
	assign bounce = net_pkt_i.valid && (net_pkt_i.dest != leaf_addr);
	assign resend_o = bounce;

	always_ff @(posedge clk) begin
		if (reset) begin
			pe_pkt_o <= '0;
			net_pkt_o <= '0;
		end else begin
			pe_pkt_o <= accept ? net_pkt_i : '0;
			// pe input goes up even when empty
			net_pkt_o <= bounce ? net_pkt_i : pe_pkt_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/root_switch.sv
`timescale 1ns/1ps
`default_nettype none

module root_switch (
	input wire clk,
	input wire reset,
	input wire nw_pkt_pkg::packet_t l_pkt_i,
	input wire nw_pkt_pkg::packet_t r_pkt_i,
	output nw_pkt_pkg::packet_t l_pkt_o,
	output nw_pkt_pkg::packet_t r_pkt_o
);

	nw_route_pkg::dir_e want_l, want_r;
	nw_route_pkg::dir_e sel_l, sel_r;

	route_decoder #(.level(0)) dec_l_i (.pkt_i(l_pkt_i), .dir_o(want_l));
	route_decoder #(.level(0)) dec_r_i (.pkt_i(r_pkt_i), .dir_o(want_r));

	// no up port here, so a loser always turns back
	always_comb begin
		sel_l = nw_route_pkg::DIR_VOID;
		sel_r = nw_route_pkg::DIR_VOID;
		if (want_l == nw_route_pkg::DIR_LEFT)
			sel_l = nw_route_pkg::DIR_LEFT;
		if (want_r == nw_route_pkg::DIR_RIGHT)
			sel_r = nw_route_pkg::DIR_RIGHT;
		// right packet crossing over, or turned back by a left turnback
		if (want_r == nw_route_pkg::DIR_LEFT) begin
			if (sel_l == nw_route_pkg::DIR_VOID)
				sel_l = nw_route_pkg::DIR_RIGHT;
			else
				sel_r = nw_route_pkg::DIR_RIGHT;
		end
		if (want_l == nw_route_pkg::DIR_RIGHT) begin
			if (sel_r == nw_route_pkg::DIR_VOID)
				sel_r = nw_route_pkg::DIR_LEFT;
			else
				sel_l = nw_route_pkg::DIR_LEFT;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			l_pkt_o <= '0;
			r_pkt_o <= '0;
		end else begin
			case (sel_l)
				nw_route_pkg::DIR_LEFT: l_pkt_o <= l_pkt_i;
				nw_route_pkg::DIR_RIGHT: l_pkt_o <= r_pkt_i;
				default: l_pkt_o <= '0;
			endcase
			case (sel_r)
				nw_route_pkg::DIR_LEFT: r_pkt_o <= l_pkt_i;
				nw_route_pkg::DIR_RIGHT: r_pkt_o <= r_pkt_i;
				default: r_pkt_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/t_switch.sv
`timescale 1ns/1ps
`default_nettype none

module t_switch #(
	parameter logic node_bit = 1'b0
) (
	input wire clk,
	input wire reset,
	input wire nw_pkt_pkg::packet_t l_pkt_i,
	input wire nw_pkt_pkg::packet_t r_pkt_i,
	input wire nw_pkt_pkg::packet_t u_pkt_i,
	output nw_pkt_pkg::packet_t l_pkt_o,
	output nw_pkt_pkg::packet_t r_pkt_o,
	output nw_pkt_pkg::packet_t u_pkt_o
);

	nw_route_pkg::dir_e want_l, want_r, want_u;
	nw_route_pkg::dir_e sel_l, sel_r, sel_u;

	// output mux, void gives an empty slot
	function automatic nw_pkt_pkg::packet_t pick(
		input nw_route_pkg::dir_e sel,
		input nw_pkt_pkg::packet_t l,
		input nw_pkt_pkg::packet_t r,
		input nw_pkt_pkg::packet_t u
	);
		case (sel)
			nw_route_pkg::DIR_LEFT: pick = l;
			nw_route_pkg::DIR_RIGHT: pick = r;
			nw_route_pkg::DIR_UP: pick = u;
			default: pick = '0;
		endcase
	endfunction

	route_decoder #(.level(1), .node_bit(node_bit)) dec_l_i (.pkt_i(l_pkt_i), .dir_o(want_l));
	route_decoder #(.level(1), .node_bit(node_bit)) dec_r_i (.pkt_i(r_pkt_i), .dir_o(want_r));
	route_decoder #(.level(1), .node_bit(node_bit)) dec_u_i (.pkt_i(u_pkt_i), .dir_o(want_u));

	t_arbiter arb_i (
		.want_l_i(want_l),
		.want_r_i(want_r),
		.want_u_i(want_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	// one cycle per hop
	always_ff @(posedge clk) begin
		if (reset) begin
			l_pkt_o <= '0;
			r_pkt_o <= '0;
			u_pkt_o <= '0;
		end else begin
			l_pkt_o <= pick(sel_l, l_pkt_i, r_pkt_i, u_pkt_i);
			r_pkt_o <= pick(sel_r, l_pkt_i, r_pkt_i, u_pkt_i);
			u_pkt_o <= pick(sel_u, l_pkt_i, r_pkt_i, u_pkt_i);
		end
	end

endmodule

`default_nettype wire

//--- hw/t_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module t_arbiter (
	input wire nw_route_pkg::dir_e want_l_i,
	input wire nw_route_pkg::dir_e want_r_i,
	input wire nw_route_pkg::dir_e want_u_i,
	output nw_route_pkg::dir_e sel_l_o,
	output nw_route_pkg::dir_e sel_r_o,
	output nw_route_pkg::dir_e sel_u_o
);

	// outputs are claimed in priority order, a free output still selects void
	// three inputs and three outputs, so the last fallback is always free
	always_comb begin
		sel_l_o = nw_route_pkg::DIR_VOID;
		sel_r_o = nw_route_pkg::DIR_VOID;
		sel_u_o = nw_route_pkg::DIR_VOID;

		// turnback packets keep their own port
		if (want_l_i == nw_route_pkg::DIR_LEFT)
			sel_l_o = nw_route_pkg::DIR_LEFT;
		if (want_r_i == nw_route_pkg::DIR_RIGHT)
			sel_r_o = nw_route_pkg::DIR_RIGHT;
		if (want_u_i == nw_route_pkg::DIR_UP)
			sel_u_o = nw_route_pkg::DIR_UP;

		// downlink, bounced back up if a turnback holds the child port
		if (want_u_i == nw_route_pkg::DIR_LEFT) begin
			if (sel_l_o == nw_route_pkg::DIR_VOID)
				sel_l_o = nw_route_pkg::DIR_UP;
			else
				sel_u_o = nw_route_pkg::DIR_UP;
		end else if (want_u_i == nw_route_pkg::DIR_RIGHT) begin
			if (sel_r_o == nw_route_pkg::DIR_VOID)
				sel_r_o = nw_route_pkg::DIR_UP;
			else
				sel_u_o = nw_route_pkg::DIR_UP;
		end

		// side links to the sibling child
		if (want_l_i == nw_route_pkg::DIR_RIGHT) begin
			if (sel_r_o == nw_route_pkg::DIR_VOID)
				sel_r_o = nw_route_pkg::DIR_LEFT;
			else if (sel_l_o == nw_route_pkg::DIR_VOID)
				sel_l_o = nw_route_pkg::DIR_LEFT;
			else
				sel_u_o = nw_route_pkg::DIR_LEFT;
		end
		if (want_r_i == nw_route_pkg::DIR_LEFT) begin
			if (sel_l_o == nw_route_pkg::DIR_VOID)
				sel_l_o = nw_route_pkg::DIR_RIGHT;
			else if (sel_r_o == nw_route_pkg::DIR_VOID)
				sel_r_o = nw_route_pkg::DIR_RIGHT;
			else
				sel_u_o = nw_route_pkg::DIR_RIGHT;
		end

		// uplinks, else back where they came from, else the other side
		if (want_l_i == nw_route_pkg::DIR_UP) begin
			if (sel_u_o == nw_route_pkg::DIR_VOID)
				sel_u_o = nw_route_pkg::DIR_LEFT;
			else if (sel_l_o == nw_route_pkg::DIR_VOID)
				sel_l_o = nw_route_pkg::DIR_LEFT;
			else
				sel_r_o = nw_route_pkg::DIR_LEFT;
		end
		if (want_r_i == nw_route_pkg::DIR_UP) begin
			if (sel_u_o == nw_route_pkg::DIR_VOID)
				sel_u_o = nw_route_pkg::DIR_RIGHT;
			else if (sel_r_o == nw_route_pkg::DIR_VOID)
				sel_r_o = nw_route_pkg::DIR_RIGHT;
			else
				sel_l_o = nw_route_pkg::DIR_RIGHT;
		end
	end

endmodule

`default_nettype wire

//--- hw/route_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "nw_defines.svh"

module route_decoder #(
	parameter int level = 1,
	parameter logic node_bit = 1'b0
) (
	input wire nw_pkt_pkg::packet_t pkt_i,
	output nw_route_pkg::dir_e dir_o
);

	// address bit that picks the child below this level
	localparam int steer_bit = `NW_ADDR_W - 1 - level;

	logic prefix_hit;

	// the root owns every address, level 1 only its own half
	assign prefix_hit = (level == 0) || (pkt_i.dest[`NW_ADDR_W-1] == node_bit);

	always_comb begin
		dir_o = nw_route_pkg::DIR_VOID;
		if (pkt_i.valid) begin
			if (!prefix_hit) begin
				dir_o = nw_route_pkg::DIR_UP;
			end else if (pkt_i.dest[steer_bit]) begin
				dir_o = nw_route_pkg::DIR_RIGHT;
			end else begin
				dir_o = nw_route_pkg::DIR_LEFT;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/nw_route_pkg.sv
`default_nettype none

package nw_route_pkg;

	// decoder result: where a packet wants to go
	// arbiter select: which input feeds an output, void empties it
	typedef enum logic [1:0] {
		DIR_VOID = 2'b00,
		DIR_LEFT = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP = 2'b11
	} dir_e;

endpackage

`default_nettype wire

//--- hw/nw_pkt_pkg.sv
`default_nettype none

`include "nw_defines.svh"

package nw_pkt_pkg;

	typedef logic [`NW_ADDR_W-1:0] leaf_addr_t;

	typedef logic [`NW_PAYLOAD_W-1:0] payload_t;

	// an invalid packet is an empty slot, all fields zero
	typedef struct packed {
		logic valid;
		leaf_addr_t dest;
		payload_t payload;
	} packet_t;

endpackage

`default_nettype wire

//--- hw/nw_defines.svh
`ifndef NW_DEFINES_SVH
`define NW_DEFINES_SVH

// network size
`define NW_NUM_LEAVES 4
`define NW_ADDR_W 2

// packet layout, valid + dest + payload
`define NW_PAYLOAD_W 6
`define NW_PKT_W 9

`endif
